// File: logic/frame_vmem.sv
// video memory, one pixel per entry
// write request registered before the array update
// read address and read data both registered, 2 cycle latency
module frame_vmem (
    input  logic                w_clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  lcd_pkg::vmem_addr_t waddr_i,
    input  lcd_pkg::pix_t       wdata_i,
    input  lcd_pkg::vmem_addr_t raddr_i,
    output lcd_pkg::pix_t       rdata_o
);

    lcd_pkg::pix_t mem [2**lcd_pkg::VMEM_ADDR_W];

    logic                we_q;
    lcd_pkg::vmem_addr_t waddr_q;
    lcd_pkg::pix_t       wdata_q;
    lcd_pkg::vmem_addr_t raddr_q;
    lcd_pkg::pix_t       rdata_q;

    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_q <= 1'b0;
        end else begin
            we_q <= we_i;
        end
    end

    always_ff @(posedge w_clk) begin
        waddr_q <= waddr_i;
        wdata_q <= wdata_i;
        if (we_q) begin
            mem[waddr_q] <= wdata_q;  // lands 2 cycles after strobe
        end
    end

    always_ff @(posedge w_clk) begin
        raddr_q <= raddr_i;
        rdata_q <= mem[raddr_q];
    end

    assign rdata_o = rdata_q;

endmodule

// File: logic/lcd_pkg.sv
// shared widths and types for the display path
// panel command codes and init data bytes
// serial word layout, bit 8 is the data/command level
package lcd_pkg;

    localparam int COORD_W     = 8;
    localparam int VMEM_ADDR_W = 2 * COORD_W;  // {row, col}
    localparam int PIX_W       = 3;            // r, g, b
    localparam int COLOR_W     = 16;           // rgb565

    typedef logic [PIX_W-1:0]       pix_t;
    typedef logic [VMEM_ADDR_W-1:0] vmem_addr_t;
    typedef logic [COLOR_W-1:0]     color_t;
    typedef logic [8:0]             lcd_word_t;  // {dc, byte}, dc=1 for data

    localparam logic [7:0] CMD_SWRESET = 8'h01;
    localparam logic [7:0] CMD_SLPOUT  = 8'h11;
    localparam logic [7:0] CMD_COLMOD  = 8'h3A;
    localparam logic [7:0] CMD_MADCTL  = 8'h36;
    localparam logic [7:0] CMD_INVON   = 8'h21;
    localparam logic [7:0] CMD_NORON   = 8'h13;
    localparam logic [7:0] CMD_DISPON  = 8'h29;
    localparam logic [7:0] CMD_CASET   = 8'h2A;
    localparam logic [7:0] CMD_RASET   = 8'h2B;
    localparam logic [7:0] CMD_RAMWR   = 8'h2C;

    localparam logic [7:0] COLMOD_RGB565  = 8'h55;  // 16 bit per pixel
    localparam logic [7:0] MADCTL_DEFAULT = 8'h00;

    localparam int INIT_LEN = 9;   // power-up words
    localparam int HDR_LEN  = 11;  // window set plus ramwr

endpackage

// File: logic/lcd_sequencer.sv
// panel power-up: reset pulse, start delay, paced init words
// endless frames: window header then rgb565 pixel bytes
// scan is column-fastest, rotation applied on the read address
module lcd_sequencer #(
    parameter int LCD_SIZE    = 240,
    parameter int LCD_ROTATE  = 0,
    parameter int RES_LOW_AT  = 100000,
    parameter int RES_HIGH_AT = 200000,
    parameter int START_AT    = 1000000,
    parameter int INIT_GAP    = 1000000
) (
    input  logic                w_clk,
    input  logic                rst_n_i,
    output logic                res_o,
    output logic                tx_en_o,
    output lcd_pkg::lcd_word_t  tx_word_o,
    input  logic                tx_busy_i,
    output lcd_pkg::vmem_addr_t pix_raddr_o,
    input  lcd_pkg::pix_t       pix_rdata_i
);

    localparam int CNT_W   = $clog2(START_AT + 2);
    localparam int GAP_W   = $clog2(INIT_GAP + 2);
    localparam int FRM_LEN = lcd_pkg::HDR_LEN + 2 * LCD_SIZE * LCD_SIZE;
    localparam int FRM_W   = $clog2(FRM_LEN + 1);

    localparam logic [lcd_pkg::COORD_W-1:0] LAST = lcd_pkg::COORD_W'(LCD_SIZE - 1);

    logic [CNT_W-1:0]            cyc_cnt_q;   // cycles since reset, saturates
    logic [GAP_W-1:0]            idle_cnt_q;  // idle cycles of the link
    logic                        res_q;
    logic                        tx_en_q;
    logic                        init_done_q;
    logic [3:0]                  init_idx_q;
    logic [FRM_W-1:0]            frm_idx_q;
    logic                        lo_byte_q;   // second byte of a pixel
    logic [lcd_pkg::COORD_W-1:0] row_q;
    logic [lcd_pkg::COORD_W-1:0] col_q;
    logic                        start_ok;
    logic                        gap_ok;
    logic                        in_pix;
    lcd_pkg::color_t             color;
    lcd_pkg::lcd_word_t          init_word;
    lcd_pkg::lcd_word_t          hdr_word;

    assign start_ok = (cyc_cnt_q == CNT_W'(START_AT));
    assign gap_ok   = (idle_cnt_q == GAP_W'(INIT_GAP));
    assign in_pix   = (frm_idx_q >= FRM_W'(lcd_pkg::HDR_LEN));

    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cyc_cnt_q  <= '0;
            idle_cnt_q <= '0;
            res_q      <= 1'b1;
        end else begin
            if (!start_ok) cyc_cnt_q <= cyc_cnt_q + 1'b1;
            if (tx_busy_i) begin
                idle_cnt_q <= '0;
            end else if (!gap_ok) begin
                idle_cnt_q <= idle_cnt_q + 1'b1;
            end
            if (cyc_cnt_q == CNT_W'(RES_LOW_AT)) begin
                res_q <= 1'b0;
            end else if (cyc_cnt_q == CNT_W'(RES_HIGH_AT)) begin
                res_q <= 1'b1;
            end
        end
    end

    // word issue and stream position
    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_en_q     <= 1'b0;
            init_done_q <= 1'b0;
            init_idx_q  <= '0;
            frm_idx_q   <= '0;
            lo_byte_q   <= 1'b0;
            row_q       <= '0;
            col_q       <= '0;
        end else begin
            if (!init_done_q) begin
                tx_en_q <= start_ok && gap_ok && !tx_busy_i;
            end else begin
                tx_en_q <= !tx_busy_i;  // back to back in frames
            end
            if (tx_en_q && !init_done_q) begin
                if (init_idx_q == 4'(lcd_pkg::INIT_LEN - 1)) begin
                    init_done_q <= 1'b1;
                end else begin
                    init_idx_q <= init_idx_q + 4'd1;
                end
            end
            if (tx_en_q && init_done_q) begin
                frm_idx_q <= (frm_idx_q == FRM_W'(FRM_LEN - 1)) ? '0 : frm_idx_q + 1'b1;
                if (in_pix) begin
                    lo_byte_q <= !lo_byte_q;
                    if (lo_byte_q) begin  // pixel done, step scan
                        col_q <= (col_q == LAST) ? '0 : col_q + 1'b1;
                        if (col_q == LAST) row_q <= (row_q == LAST) ? '0 : row_q + 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        case (init_idx_q)
            4'd0:    init_word = {1'b0, lcd_pkg::CMD_SWRESET};
            4'd1:    init_word = {1'b0, lcd_pkg::CMD_SLPOUT};
            4'd2:    init_word = {1'b0, lcd_pkg::CMD_COLMOD};
            4'd3:    init_word = {1'b1, lcd_pkg::COLMOD_RGB565};
            4'd4:    init_word = {1'b0, lcd_pkg::CMD_MADCTL};
            4'd5:    init_word = {1'b1, lcd_pkg::MADCTL_DEFAULT};
            4'd6:    init_word = {1'b0, lcd_pkg::CMD_INVON};
            4'd7:    init_word = {1'b0, lcd_pkg::CMD_NORON};
            default: init_word = {1'b0, lcd_pkg::CMD_DISPON};
        endcase
    end

    always_comb begin
        case (frm_idx_q)
            FRM_W'(0):  hdr_word = {1'b0, lcd_pkg::CMD_CASET};
            FRM_W'(4):  hdr_word = {1'b1, LAST};  // column end
            FRM_W'(5):  hdr_word = {1'b0, lcd_pkg::CMD_RASET};
            FRM_W'(9):  hdr_word = {1'b1, LAST};  // row end
            FRM_W'(10): hdr_word = {1'b0, lcd_pkg::CMD_RAMWR};
            default:    hdr_word = {1'b1, 8'h00};  // window start bytes
        endcase
    end

    // 3 bit pixel to rgb565 by bit replication
    assign color = {{5{pix_rdata_i[2]}}, {6{pix_rdata_i[1]}}, {5{pix_rdata_i[0]}}};

    always_comb begin
        if (!init_done_q) begin
            tx_word_o = init_word;
        end else if (!in_pix) begin
            tx_word_o = hdr_word;
        end else begin
            tx_word_o = {1'b1, lo_byte_q ? color[7:0] : color[15:8]};
        end
    end

    always_comb begin
        case (LCD_ROTATE)
            1:       pix_raddr_o = {col_q, LAST - row_q};
            2:       pix_raddr_o = {LAST - row_q, LAST - col_q};
            3:       pix_raddr_o = {LAST - col_q, row_q};
            default: pix_raddr_o = {row_q, col_q};
        endcase
    end

    assign res_o   = res_q;
    assign tx_en_o = tx_en_q;

endmodule

// File: logic/lcd_top.sv
// display subsystem top level
// video memory, frame sequencer and serial link
module lcd_top #(
    parameter int LCD_SIZE    = 240,
    parameter int LCD_ROTATE  = 0,
    parameter int RES_LOW_AT  = 100000,
    parameter int RES_HIGH_AT = 200000,
    parameter int START_AT    = 1000000,
    parameter int INIT_GAP    = 1000000
) (
    input  logic                w_clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  lcd_pkg::vmem_addr_t waddr_i,
    input  lcd_pkg::pix_t       wdata_i,
    output logic                lcd_sda_o,
    output logic                lcd_scl_o,
    output logic                lcd_dc_o,
    output logic                lcd_res_o
);

    lcd_pkg::vmem_addr_t pix_raddr;
    lcd_pkg::pix_t       pix_rdata;
    logic                tx_en;
    lcd_pkg::lcd_word_t  tx_word;
    logic                tx_busy;

    frame_vmem i_vmem (
        .w_clk   (w_clk),
        .rst_n_i (rst_n_i),
        .we_i    (we_i),
        .waddr_i (waddr_i),
        .wdata_i (wdata_i),
        .raddr_i (pix_raddr),
        .rdata_o (pix_rdata)
    );

    lcd_sequencer #(
        .LCD_SIZE    (LCD_SIZE),
        .LCD_ROTATE  (LCD_ROTATE),
        .RES_LOW_AT  (RES_LOW_AT),
        .RES_HIGH_AT (RES_HIGH_AT),
        .START_AT    (START_AT),
        .INIT_GAP    (INIT_GAP)
    ) i_seq (
        .w_clk       (w_clk),
        .rst_n_i     (rst_n_i),
        .res_o       (lcd_res_o),
        .tx_en_o     (tx_en),
        .tx_word_o   (tx_word),
        .tx_busy_i   (tx_busy),
        .pix_raddr_o (pix_raddr),
        .pix_rdata_i (pix_rdata)
    );

    spi_byte_tx i_spi (
        .w_clk   (w_clk),
        .rst_n_i (rst_n_i),
        .en_i    (tx_en),
        .word_i  (tx_word),
        .sda_o   (lcd_sda_o),
        .scl_o   (lcd_scl_o),
        .dc_o    (lcd_dc_o),
        .busy_o  (tx_busy)
    );

endmodule

// File: logic/spi_byte_tx.sv
// serializer for one 9-bit panel word
// clock idles high, msb first, sda changes while scl is high
// dc level held for the whole byte
module spi_byte_tx (
    input  logic               w_clk,
    input  logic               rst_n_i,
    input  logic               en_i,
    input  lcd_pkg::lcd_word_t word_i,
    output logic               sda_o,
    output logic               scl_o,
    output logic               dc_o,
    output logic               busy_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_CLK_LO,
        ST_CLK_HOLD,
        ST_CLK_HI
    } state_t;

    state_t     state_q;
    logic [3:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic       sda_q;
    logic       scl_q;
    logic       dc_q;

    always_ff @(posedge w_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            bit_cnt_q <= '0;
            sda_q     <= 1'b0;
            scl_q     <= 1'b1;
            dc_q      <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (en_i) begin
                        dc_q      <= word_i[8];
                        bit_cnt_q <= '0;
                        state_q   <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    sda_q     <= shift_q[7];  // present next bit
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                    state_q   <= ST_CLK_LO;
                end
                ST_CLK_LO: begin
                    scl_q   <= 1'b0;
                    state_q <= ST_CLK_HOLD;
                end
                ST_CLK_HOLD: state_q <= ST_CLK_HI;
                ST_CLK_HI: begin
                    scl_q   <= 1'b1;  // panel samples here
                    state_q <= (bit_cnt_q == 4'd8) ? ST_IDLE : ST_LOAD;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // byte shifter
    always_ff @(posedge w_clk) begin
        if (state_q == ST_IDLE && en_i) begin
            shift_q <= word_i[7:0];
        end else if (state_q == ST_LOAD) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign sda_o  = sda_q;
    assign scl_o  = scl_q;
    assign dc_o   = dc_q;
    assign busy_o = (state_q != ST_IDLE) || en_i;

endmodule

// File: project.f
logic/lcd_pkg.sv
logic/frame_vmem.sv
logic/spi_byte_tx.sv
logic/lcd_sequencer.sv
logic/lcd_top.sv
verification/tb_clock_gen.sv
verification/tb_lcd_top.sv

// File: run.sh
#!/usr/bin/env bash
# builds the display testbench with verilator, runs it, checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_lcd_top \
    -f project.f -o tb_lcd_top_sim \
    && ./obj_dir/tb_lcd_top_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/tb_clock_gen.sv
// testbench clock and reset source
// 100 ns clock, active low reset held for a fixed number of cycles
module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic w_clk,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        w_clk = 1'b0;
        forever #50 w_clk = ~w_clk;  // 100 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge w_clk);
        #10 rst_n_o = 1'b1;  // release just after the edge
    end

endmodule

// File: verification/tb_lcd_top.sv
// testbench for the display subsystem
// writes random pixels, decodes the serial link into 9-bit words
// reference model for init, header and rotated pixel words over two frames
module tb_lcd_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SIZE          = 8;
    localparam int ROTATE        = 1;
    localparam int FRAME_WORDS   = lcd_pkg::HDR_LEN + 2 * SIZE * SIZE;
    localparam int TOTAL_WORDS   = lcd_pkg::INIT_LEN + 2 * FRAME_WORDS;
    localparam int WORD_TIMEOUT  = 2000;  // cycles per word
    localparam int RESET_TIMEOUT = 100;
    localparam int DRIVE_DELAY   = 10;    // ns after the rising edge

    logic                w_clk;
    logic                rst_n;
    logic                we;
    lcd_pkg::vmem_addr_t waddr;
    lcd_pkg::pix_t       wdata;
    logic                lcd_sda;
    logic                lcd_scl;
    logic                lcd_dc;
    logic                lcd_res;

    lcd_pkg::pix_t model_pix [SIZE][SIZE];  // [row][col] as addressed in memory
    logic [8:0]    rx_q [$];                // decoded serial words
    int            seed        = 76232;
    int            mismatches  = 0;
    int            timeouts    = 0;

    // link monitor state
    logic       res_prev    = 1'b1;
    logic       scl_prev    = 1'b1;
    int         bit_cnt     = 0;
    logic [7:0] shift       = '0;
    logic       dc_cap      = 1'b0;
    int         res_falls   = 0;
    int         res_rises   = 0;
    bit         tx_started  = 1'b0;
    int         falls_at_tx = 0;
    int         rises_at_tx = 0;

    tb_clock_gen #(.RESET_CYCLES(16)) i_clk_gen (
        .w_clk   (w_clk),
        .rst_n_o (rst_n)
    );

    lcd_top #(
        .LCD_SIZE    (SIZE),
        .LCD_ROTATE  (ROTATE),
        .RES_LOW_AT  (20),
        .RES_HIGH_AT (40),
        .START_AT    (400),
        .INIT_GAP    (100)
    ) i_dut (
        .w_clk     (w_clk),
        .rst_n_i   (rst_n),
        .we_i      (we),
        .waddr_i   (waddr),
        .wdata_i   (wdata),
        .lcd_sda_o (lcd_sda),
        .lcd_scl_o (lcd_scl),
        .lcd_dc_o  (lcd_dc),
        .lcd_res_o (lcd_res)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic write_pixel(input lcd_pkg::vmem_addr_t addr, input lcd_pkg::pix_t data);
        @(posedge w_clk);
        #DRIVE_DELAY;
        we    = 1'b1;
        waddr = addr;
        wdata = data;
    endtask

    task automatic end_writes();
        @(posedge w_clk);
        #DRIVE_DELAY;
        we = 1'b0;
    endtask

    task automatic wait_word(input int idx, output bit ok);
        int cycles;
        cycles = 0;
        while (rx_q.size() == 0 && cycles < WORD_TIMEOUT) begin
            @(posedge w_clk);
            cycles++;
        end
        ok = (rx_q.size() != 0);
        if (!ok) begin
            timeouts++;
            $display("serial word %0d never arrived within %0d cycles", idx, WORD_TIMEOUT);
        end
    endtask

    // expected word at any position of the stream
    function automatic logic [8:0] expected_word(input int idx);
        int            pos;
        int            pix_n;
        int            r;
        int            c;
        int            ar;
        int            ac;
        int            m;
        lcd_pkg::pix_t p;
        logic [15:0]   rgb;
        m = SIZE - 1;
        if (idx < lcd_pkg::INIT_LEN) begin
            case (idx)
                0:       return {1'b0, lcd_pkg::CMD_SWRESET};
                1:       return {1'b0, lcd_pkg::CMD_SLPOUT};
                2:       return {1'b0, lcd_pkg::CMD_COLMOD};
                3:       return {1'b1, lcd_pkg::COLMOD_RGB565};
                4:       return {1'b0, lcd_pkg::CMD_MADCTL};
                5:       return {1'b1, lcd_pkg::MADCTL_DEFAULT};
                6:       return {1'b0, lcd_pkg::CMD_INVON};
                7:       return {1'b0, lcd_pkg::CMD_NORON};
                default: return {1'b0, lcd_pkg::CMD_DISPON};
            endcase
        end
        pos = (idx - lcd_pkg::INIT_LEN) % FRAME_WORDS;
        if (pos < lcd_pkg::HDR_LEN) begin
            case (pos)
                0:       return {1'b0, lcd_pkg::CMD_CASET};
                4, 9:    return {1'b1, 8'(m)};  // window end
                5:       return {1'b0, lcd_pkg::CMD_RASET};
                10:      return {1'b0, lcd_pkg::CMD_RAMWR};
                default: return {1'b1, 8'h00};
            endcase
        end
        pix_n = (pos - lcd_pkg::HDR_LEN) / 2;
        r     = pix_n / SIZE;  // column-fastest scan
        c     = pix_n % SIZE;
        case (ROTATE)
            1: begin
                ar = c;
                ac = m - r;
            end
            2: begin
                ar = m - r;
                ac = m - c;
            end
            3: begin
                ar = m - c;
                ac = r;
            end
            default: begin
                ar = r;
                ac = c;
            end
        endcase
        p   = model_pix[ar][ac];
        rgb = 16'h0000;
        if (p[2]) rgb = rgb | 16'hF800;  // red field
        if (p[1]) rgb = rgb | 16'h07E0;  // green field
        if (p[0]) rgb = rgb | 16'h001F;  // blue field
        if ((pos - lcd_pkg::HDR_LEN) % 2 == 0) return {1'b1, rgb[15:8]};
        return {1'b1, rgb[7:0]};
    endfunction

    // serial link decoder sampled between clock edges
    always @(negedge w_clk) begin
        if (rst_n) begin
            if (lcd_res != res_prev) begin
                if (lcd_res) begin
                    res_rises++;
                end else begin
                    res_falls++;
                end
            end
            if (!tx_started && scl_prev && !lcd_scl) begin  // first bit of the link
                tx_started  = 1'b1;
                falls_at_tx = res_falls;
                rises_at_tx = res_rises;
            end
            if (lcd_scl && !scl_prev) begin
                if (bit_cnt == 0) dc_cap = lcd_dc;
                shift = {shift[6:0], lcd_sda};
                bit_cnt++;
                if (bit_cnt == 8) begin
                    rx_q.push_back({dc_cap, shift});
                    bit_cnt = 0;
                end
            end
            res_prev = lcd_res;
            scl_prev = lcd_scl;
        end
    end

    initial begin : main_flow
        int         cycles;
        int         rnd;
        bit         ok;
        logic [8:0] got;
        we     = 1'b0;
        waddr  = '0;
        wdata  = '0;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge w_clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released within %0d cycles", RESET_TIMEOUT);
        end else begin
            check_value("lcd_scl_o idle after reset", 32'(lcd_scl), 1);
            check_value("lcd_res_o after reset", 32'(lcd_res), 1);
            check_value("lcd_dc_o after reset", 32'(lcd_dc), 0);
            check_value("lcd_sda_o after reset", 32'(lcd_sda), 0);
            for (int r = 0; r < SIZE; r++) begin
                for (int c = 0; c < SIZE; c++) begin
                    rnd = $random(seed);
                    model_pix[r][c] = rnd[2:0];
                    write_pixel({8'(r), 8'(c)}, rnd[2:0]);
                end
            end
            // off-screen writes must not reach the picture
            for (int k = 0; k < SIZE; k++) begin
                rnd = $random(seed);
                write_pixel({8'(SIZE + k), 8'(k)}, rnd[2:0]);
                write_pixel({8'(k), 8'(SIZE + k)}, rnd[5:3]);
            end
            end_writes();
            for (int idx = 0; idx < TOTAL_WORDS; idx++) begin
                wait_word(idx, ok);
                if (!ok) break;
                got = rx_q.pop_front();
                check_value($sformatf("serial word %0d", idx), 32'(got),
                            32'(expected_word(idx)));
                check_value("lcd_scl_o idle between words", 32'(lcd_scl), 1);
            end
            check_value("lcd_res_o falls before first word", falls_at_tx, 1);
            check_value("lcd_res_o rises before first word", rises_at_tx, 1);
            check_value("lcd_res_o pulses once", res_falls + res_rises, 2);
            check_value("lcd_res_o high at end", 32'(lcd_res), 1);
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
